//--- hdl/cpu_pkg.sv
package cpu_pkg;

    // vector types
    typedef logic [31:0] word_t;     // data, address and instruction word
    typedef logic [4:0]  opcode_t;   // ir[31:27]
    typedef logic [3:0]  reg_idx_t;  // ra, rb or rc field
    typedef logic [2:0]  step_t;     // T0 to T7
    typedef logic [3:0]  src_sel_t;  // one-hot bus source

    // opcode values with 2 left unused
    localparam opcode_t op_ldw  = 5'd0;
    localparam opcode_t op_stw  = 5'd1;
    localparam opcode_t op_add  = 5'd3;
    localparam opcode_t op_sub  = 5'd4;
    localparam opcode_t op_and  = 5'd5;
    localparam opcode_t op_or   = 5'd6;
    localparam opcode_t op_halt = 5'd27;

    // instruction field positions
    localparam int opcode_lsb = 27;
    localparam int ra_lsb     = 23;
    localparam int rb_lsb     = 19;
    localparam int rc_lsb     = 15;

    // bit positions inside src_sel_t
    localparam int src_regs = 0;
    localparam int src_pc   = 1;
    localparam int src_mdr  = 2;
    localparam int src_zlow = 3;

endpackage

//--- hdl/step_counter.sv
`timescale 1ns/1ps

module step_counter (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           run,
    input  logic           end_instr,
    output cpu_pkg::step_t step
);

    // T-step of the instruction in flight
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            step <= '0;
        end
        else if (end_instr)
        begin
            step <= '0;             // next fetch starts at T0
        end
        else if (run)
        begin
            step <= step + 3'd1;
        end
    end

endmodule

//--- hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::step_t     step,
    input  cpu_pkg::opcode_t   opcode,
    output logic               run,
    output logic               end_instr,
    output logic               pc_in,
    output logic               ir_in,
    output logic               mar_in,
    output logic               mdr_in,
    output logic               y_in,
    output logic               z_in,
    output logic               reg_in,
    output logic               mem_read,
    output logic               mem_write,
    output logic               inc_pc,
    output logic               reg_sel_a,
    output logic               reg_sel_b,
    output logic               reg_sel_c,
    output logic               halted,
    output cpu_pkg::src_sel_t  src_sel,
    output cpu_pkg::opcode_t   alu_op
);

    typedef enum logic [1:0] {cu_reset, cu_run, cu_halt} cu_state_t;

    cu_state_t state;
    cu_state_t state_next;
    logic      is_alu;
    logic      is_ldw;
    logic      is_stw;
    logic      is_halt;

    assign is_alu  = (opcode == cpu_pkg::op_add) || (opcode == cpu_pkg::op_sub) ||
                     (opcode == cpu_pkg::op_and) || (opcode == cpu_pkg::op_or);
    assign is_ldw  = (opcode == cpu_pkg::op_ldw);
    assign is_stw  = (opcode == cpu_pkg::op_stw);
    assign is_halt = (opcode == cpu_pkg::op_halt);

    // cu_reset covers the first cycle after reset, fetch T0 already runs in it
    assign run    = (state != cu_halt);
    assign halted = (state == cu_halt);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= cu_reset;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        case (state)
            cu_reset: state_next = cu_run;
            cu_run:   state_next = (is_halt && step == 3'd3) ? cu_halt : cu_run;
            cu_halt:  state_next = cu_halt;   // left only through reset
            default:  state_next = cu_reset;
        endcase
    end

    // step and opcode to strobes
    always_comb
    begin
        end_instr = 1'b0;
        pc_in     = 1'b0;
        ir_in     = 1'b0;
        mar_in    = 1'b0;
        mdr_in    = 1'b0;
        y_in      = 1'b0;
        z_in      = 1'b0;
        reg_in    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        inc_pc    = 1'b0;
        reg_sel_a = 1'b0;
        reg_sel_b = 1'b0;
        reg_sel_c = 1'b0;
        src_sel   = '0;
        alu_op    = '0;
        if (run)
        begin
            case (step)
                3'd0:
                begin
                    src_sel[cpu_pkg::src_pc] = 1'b1;    // mar <- pc, z <- pc + 1
                    mar_in = 1'b1;
                    z_in   = 1'b1;
                    inc_pc = 1'b1;
                end
                3'd1:
                begin
                    src_sel[cpu_pkg::src_zlow] = 1'b1;  // pc <- zlow, mdr <- mem
                    pc_in    = 1'b1;
                    mem_read = 1'b1;
                    mdr_in   = 1'b1;
                end
                3'd2:
                begin
                    src_sel[cpu_pkg::src_mdr] = 1'b1;   // ir <- mdr
                    ir_in = 1'b1;
                end
                3'd3:
                begin
                    if (is_alu)
                    begin
                        src_sel[cpu_pkg::src_regs] = 1'b1;  // y <- rb
                        reg_sel_b = 1'b1;
                        y_in      = 1'b1;
                    end
                    else if (is_ldw || is_stw)
                    begin
                        src_sel[cpu_pkg::src_pc] = 1'b1;    // address of operand word
                        mar_in = 1'b1;
                        z_in   = 1'b1;
                        inc_pc = 1'b1;
                    end
                    else
                    begin
                        end_instr = 1'b1;   // halt, unknown opcodes act as nop
                    end
                end
                3'd4:
                begin
                    if (is_alu)
                    begin
                        src_sel[cpu_pkg::src_regs] = 1'b1;  // z <- y op rc
                        reg_sel_c = 1'b1;
                        alu_op    = opcode;
                        z_in      = 1'b1;
                    end
                    else
                    begin
                        src_sel[cpu_pkg::src_zlow] = 1'b1;  // skip pc past the operand
                        pc_in    = 1'b1;
                        mem_read = 1'b1;
                        mdr_in   = 1'b1;
                    end
                end
                3'd5:
                begin
                    if (is_alu)
                    begin
                        src_sel[cpu_pkg::src_zlow] = 1'b1;
                        reg_sel_a = 1'b1;
                        reg_in    = 1'b1;
                        end_instr = 1'b1;
                    end
                    else if (is_ldw)
                    begin
                        src_sel[cpu_pkg::src_mdr] = 1'b1;   // ra <- loaded word
                        reg_sel_a = 1'b1;
                        reg_in    = 1'b1;
                        end_instr = 1'b1;
                    end
                    else
                    begin
                        src_sel[cpu_pkg::src_mdr] = 1'b1;   // store address to mar
                        mar_in = 1'b1;
                    end
                end
                3'd6:
                begin
                    src_sel[cpu_pkg::src_regs] = 1'b1;      // stw only, mdr <- ra
                    reg_sel_a = 1'b1;
                    mdr_in    = 1'b1;
                end
                default:
                begin
                    mem_write = 1'b1;                       // stw T7
                    end_instr = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int num_regs = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::word_t    bus,
    input  logic              reg_in,
    input  cpu_pkg::reg_idx_t sel_idx,
    output cpu_pkg::word_t    reg_out
);

    localparam int idx_w = $clog2(num_regs);

    cpu_pkg::word_t   regs [num_regs];
    logic [idx_w-1:0] idx;

    // only the low bits address the file when num_regs is 8
    assign idx = sel_idx[idx_w-1:0];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (reg_in)
        begin
            regs[idx] <= bus;
        end
    end

    assign reg_out = regs[idx];   // selected register always on the mux input

endmodule

//--- hdl/special_regs.sv
`timescale 1ns/1ps

module special_regs (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::word_t    bus,
    input  logic              pc_in,
    input  logic              ir_in,
    input  logic              mar_in,
    input  logic              mdr_in,
    input  logic              mem_read,
    input  logic              reg_sel_a,
    input  logic              reg_sel_b,
    input  logic              reg_sel_c,
    input  cpu_pkg::word_t    mem_rdata,
    output cpu_pkg::word_t    pc,
    output cpu_pkg::word_t    mdr,
    output cpu_pkg::word_t    mar,
    output cpu_pkg::opcode_t  opcode,
    output cpu_pkg::reg_idx_t sel_idx
);

    cpu_pkg::word_t ir;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc  <= '0;   // fetch begins at address 0
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
        end
        else
        begin
            if (pc_in)  pc  <= bus;
            if (ir_in)  ir  <= bus;
            if (mar_in) mar <= bus;
            if (mdr_in) mdr <= mem_read ? mem_rdata : bus;  // memory wins on a read
        end
    end

    assign opcode = ir[cpu_pkg::opcode_lsb +: 5];

    // register field chosen by the gra/grb/grc strobes
    always_comb
    begin
        if (reg_sel_a)
            sel_idx = ir[cpu_pkg::ra_lsb +: 4];
        else if (reg_sel_b)
            sel_idx = ir[cpu_pkg::rb_lsb +: 4];
        else if (reg_sel_c)
            sel_idx = ir[cpu_pkg::rc_lsb +: 4];
        else
            sel_idx = '0;
    end

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic             clk,
    input  logic             arst_n,
    input  cpu_pkg::word_t   bus,
    input  logic             y_in,
    input  logic             z_in,
    input  logic             inc_pc,
    input  cpu_pkg::opcode_t alu_op,
    output cpu_pkg::word_t   zlow
);

    cpu_pkg::word_t y;
    cpu_pkg::word_t z;
    cpu_pkg::word_t result;

    always_comb
    begin
        if (inc_pc)
        begin
            result = bus + 32'd1;   // pc + 1 during fetch
        end
        else
        begin
            case (alu_op)
                cpu_pkg::op_and: result = y & bus;
                cpu_pkg::op_or:  result = y | bus;
                cpu_pkg::op_add: result = y + bus;
                cpu_pkg::op_sub: result = y - bus;   // y holds rb, bus holds rc
                default:         result = bus;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            y <= '0;
            z <= '0;
        end
        else
        begin
            if (y_in) y <= bus;
            if (z_in) z <= result;
        end
    end

    assign zlow = z;   // no zhigh on this machine

endmodule

//--- hdl/bus_mux.sv
`timescale 1ns/1ps

module bus_mux (
    input  cpu_pkg::src_sel_t src_sel,
    input  cpu_pkg::word_t    reg_out,
    input  cpu_pkg::word_t    pc,
    input  cpu_pkg::word_t    mdr,
    input  cpu_pkg::word_t    zlow,
    output cpu_pkg::word_t    bus
);

    // and-or of one-hot sources, all zero gives an idle bus of 0
    always_comb
    begin
        bus = '0;
        if (src_sel[cpu_pkg::src_regs]) bus = bus | reg_out;
        if (src_sel[cpu_pkg::src_pc])   bus = bus | pc;
        if (src_sel[cpu_pkg::src_mdr])  bus = bus | mdr;
        if (src_sel[cpu_pkg::src_zlow]) bus = bus | zlow;
    end

endmodule

//--- hdl/cpu_datapath_top.sv
`timescale 1ns/1ps

module cpu_datapath_top #(
    parameter int num_regs = 16
) (
    input  logic           clk,
    input  logic           arst_n,
    input  cpu_pkg::word_t mem_rdata,
    output cpu_pkg::word_t mem_addr,
    output cpu_pkg::word_t mem_wdata,
    output logic           mem_read,
    output logic           mem_write,
    output logic           halted
);

    cpu_pkg::step_t    step;
    cpu_pkg::opcode_t  opcode;
    cpu_pkg::opcode_t  alu_op;
    cpu_pkg::src_sel_t src_sel;
    cpu_pkg::reg_idx_t sel_idx;
    cpu_pkg::word_t    bus;
    cpu_pkg::word_t    reg_out;
    cpu_pkg::word_t    pc;
    cpu_pkg::word_t    mdr;
    cpu_pkg::word_t    zlow;
    logic run;
    logic end_instr;
    logic pc_in;
    logic ir_in;
    logic mar_in;
    logic mdr_in;
    logic y_in;
    logic z_in;
    logic reg_in;
    logic inc_pc;
    logic reg_sel_a;
    logic reg_sel_b;
    logic reg_sel_c;

    assign mem_wdata = mdr;   // stores always come from mdr

    step_counter step_counter_inst (
        .clk(clk), .arst_n(arst_n), .run(run), .end_instr(end_instr), .step(step)
    );

    control_unit control_unit_inst (
        .clk(clk), .arst_n(arst_n), .step(step), .opcode(opcode),
        .run(run), .end_instr(end_instr),
        .pc_in(pc_in), .ir_in(ir_in), .mar_in(mar_in), .mdr_in(mdr_in),
        .y_in(y_in), .z_in(z_in), .reg_in(reg_in),
        .mem_read(mem_read), .mem_write(mem_write), .inc_pc(inc_pc),
        .reg_sel_a(reg_sel_a), .reg_sel_b(reg_sel_b), .reg_sel_c(reg_sel_c),
        .halted(halted), .src_sel(src_sel), .alu_op(alu_op)
    );

    register_file #(.num_regs(num_regs)) register_file_inst (
        .clk(clk), .arst_n(arst_n), .bus(bus), .reg_in(reg_in),
        .sel_idx(sel_idx), .reg_out(reg_out)
    );

    special_regs special_regs_inst (
        .clk(clk), .arst_n(arst_n), .bus(bus),
        .pc_in(pc_in), .ir_in(ir_in), .mar_in(mar_in), .mdr_in(mdr_in),
        .mem_read(mem_read),
        .reg_sel_a(reg_sel_a), .reg_sel_b(reg_sel_b), .reg_sel_c(reg_sel_c),
        .mem_rdata(mem_rdata),
        .pc(pc), .mdr(mdr), .mar(mem_addr), .opcode(opcode), .sel_idx(sel_idx)
    );

    alu_unit alu_unit_inst (
        .clk(clk), .arst_n(arst_n), .bus(bus), .y_in(y_in), .z_in(z_in),
        .inc_pc(inc_pc), .alu_op(alu_op), .zlow(zlow)
    );

    bus_mux bus_mux_inst (
        .src_sel(src_sel), .reg_out(reg_out), .pc(pc), .mdr(mdr), .zlow(zlow), .bus(bus)
    );

endmodule

//--- dv/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input logic clk,
    input logic arst_n,
    input logic mem_read,
    input logic mem_write,
    input logic halted
);

    // one memory access per cycle at most
    no_read_write_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_read && mem_write))
    else $error("mem_read and mem_write high together");

    read_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        mem_read |=> !mem_read)
    else $error("mem_read held past one cycle");

    write_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        mem_write |=> !mem_write)
    else $error("mem_write held past one cycle");

    // halt is left only through reset
    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
    else $error("halted dropped");

    halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !(mem_read || mem_write))
    else $error("memory access after halt");

endmodule

bind cpu_datapath_top cpu_checker cpu_checker_inst (
    .clk(clk), .arst_n(arst_n), .mem_read(mem_read), .mem_write(mem_write), .halted(halted)
);

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    // opcode values and program layout
    localparam logic [4:0] op_ldw  = 5'd0;
    localparam logic [4:0] op_stw  = 5'd1;
    localparam logic [4:0] op_add  = 5'd3;
    localparam logic [4:0] op_sub  = 5'd4;
    localparam logic [4:0] op_and  = 5'd5;
    localparam logic [4:0] op_or   = 5'd6;
    localparam logic [4:0] op_halt = 5'd27;
    localparam int store_base = 40;
    localparam int read_count = 29;     // fetches plus operand words at 0 to 28
    localparam int halt_limit = 400;

    logic        clk;
    logic        arst_n;
    logic [31:0] mem_rdata;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_read;
    logic        mem_write;
    logic        halted;

    logic [31:0] mem [64];
    logic [31:0] opnd [4];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       exp_name [$];
    logic [31:0] next_read_addr = '0;
    logic        read_d = 1'b0;
    logic        write_d = 1'b0;
    logic        halted_d = 1'b0;
    logic        timed_out = 1'b0;
    integer      seed;
    integer      cycles;
    integer      tests_run = 0;
    integer      tests_failed = 0;
    integer      fetch_errs = 0;
    integer      strobe_errs = 0;

    cpu_datapath_top #(.num_regs(16)) cpu_datapath_top_inst (
        .clk(clk), .arst_n(arst_n), .mem_rdata(mem_rdata),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_read(mem_read), .mem_write(mem_write), .halted(halted)
    );

    assign mem_rdata = mem[mem_addr[5:0]];  // memory answers in the same cycle

    always @(posedge clk)
    begin
        if (arst_n && mem_write)
            mem[mem_addr[5:0]] <= mem_wdata;
    end

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] encode_instr(input logic [4:0] op, input logic [3:0] ra,
                                                 input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    task automatic expect_store(input string name, input logic [31:0] data);
        exp_addr.push_back(32'(store_base + exp_addr.size()));
        exp_data.push_back(data);
        exp_name.push_back(name);
    endtask

    task automatic report_test(input string name, input logic ok);
        tests_run++;
        if (ok)
        begin
            $display("test %-14s ok", name);
        end
        else
        begin
            $display("test %-14s FAILED", name);
            tests_failed++;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < 64; i++)
        begin
            mem[i] <= 32'hf000_0000 | 32'(i);   // unused words decode as nops
        end
        for (int i = 0; i < 4; i++)
        begin
            opnd[i] = $random(seed);
            mem[2*i]     <= encode_instr(op_ldw, 4'(i + 1), 4'd0, 4'd0);
            mem[2*i + 1] <= opnd[i];
        end
        mem[8]  <= encode_instr(op_add, 4'd5, 4'd1, 4'd2);
        mem[9]  <= encode_instr(op_sub, 4'd6, 4'd3, 4'd4);  // r6 = r3 - r4
        mem[10] <= encode_instr(op_and, 4'd7, 4'd1, 4'd3);
        mem[11] <= encode_instr(op_or,  4'd8, 4'd2, 4'd4);
        for (int r = 1; r <= 8; r++)
        begin
            mem[10 + 2*r] <= encode_instr(op_stw, 4'(r), 4'd0, 4'd0);
            mem[11 + 2*r] <= 32'(store_base + r - 1);       // store target address
        end
        mem[28] <= encode_instr(op_halt, 4'd0, 4'd0, 4'd0);
        for (int i = 0; i < 4; i++)
        begin
            expect_store($sformatf("ldw_stw_r%0d", i + 1), opnd[i]);
        end
        expect_store("add", opnd[0] + opnd[1]);
        expect_store("sub", opnd[2] - opnd[3]);
        expect_store("and", opnd[0] & opnd[2]);
        expect_store("or", opnd[1] | opnd[3]);
    endtask

    task automatic check_store();
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        logic        ok;
        if (exp_name.size() == 0)
        begin
            $display("store to address %h that the program never issues", mem_addr);
            strobe_errs++;
        end
        else
        begin
            name = exp_name.pop_front();
            a = exp_addr.pop_front();
            d = exp_data.pop_front();
            ok = 1'b1;
            assert (mem_addr == a)
            else
            begin
                $display("ERROR %s address expected %h actual %h", name, a, mem_addr);
                ok = 1'b0;
            end
            assert (mem_wdata == d)
            else
            begin
                $display("ERROR %s data expected %h actual %h", name, d, mem_wdata);
                ok = 1'b0;
            end
            report_test(name, ok);
        end
    endtask

    task automatic strobe_fault(input string msg);
        $display("strobe check: %s", msg);
        strobe_errs++;
    endtask

    // read order, stores and strobe rules sampled on each edge
    always @(posedge clk)
    begin
        if (arst_n)
        begin
            if (mem_read)
            begin
                assert (mem_addr == next_read_addr)
                else
                begin
                    $display("ERROR fetch_order expected %h actual %h", next_read_addr, mem_addr);
                    fetch_errs++;
                end
                next_read_addr = next_read_addr + 32'd1;
            end
            if (mem_write)
                check_store();
            assert (!(mem_read && mem_write))
            else strobe_fault("mem_read and mem_write high in the same cycle");
            assert (!(mem_read && read_d))
            else strobe_fault("mem_read high for more than one cycle");
            assert (!(mem_write && write_d))
            else strobe_fault("mem_write high for more than one cycle");
            assert (!(halted_d && !halted))
            else strobe_fault("halted dropped without a reset");
            assert (!(halted && (mem_read || mem_write)))
            else strobe_fault("memory strobe while halted");
            read_d = mem_read;
            write_d = mem_write;
            halted_d = halted;
        end
    end

    initial
    begin
        seed = 32'h2dda;
        arst_n = 1'b0;
        load_program();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        assert ({mem_read, mem_write, halted} == 3'b000)
        else $display("ERROR reset expected 000 actual %b", {mem_read, mem_write, halted});
        report_test("reset", {mem_read, mem_write, halted} == 3'b000);

        cycles = 0;
        while (!halted && cycles < halt_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!halted)
        begin
            $display("timeout: halted still low after %0d cycles", cycles);
            timed_out = 1'b1;
        end
        repeat (10) @(posedge clk);     // watch for strobes after halt
        @(negedge clk);

        assert (next_read_addr == 32'(read_count))
        else $display("ERROR fetch_order expected %0d reads actual %0d", read_count,
                      next_read_addr);
        report_test("fetch_order", fetch_errs == 0 && next_read_addr == 32'(read_count));
        assert (exp_name.size() == 0)
        else $display("%0d expected stores never happened", exp_name.size());
        report_test("halt", halted && strobe_errs == 0 && exp_name.size() == 0);

        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0 && !timed_out)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- sources.f
hdl/cpu_pkg.sv
hdl/step_counter.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/special_regs.sv
hdl/alu_unit.sv
hdl/bus_mux.sv
hdl/cpu_datapath_top.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sources.f --top-module cpu_tb -o cpu_tb_sim
	./obj_dir/cpu_tb_sim +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f --top-module cpu_tb

clean:
	rm -rf obj_dir $(LOG)
